/* bench/hss_link_tb.sv */
// ----------------------------------------------------------
// Loopback testbench of the link control layer
// Transceiver is modelled as a byte rotation of txdata_o
// Traffic is stopped and drained before each loss of sync
// ----------------------------------------------------------
`timescale 1ns/10ps

module hss_link_tb;
  import hss_link_pkg::*;

  localparam int RESET_CYCLES = 3;
  localparam int SEGMENTS     = 4;
  localparam int LINK_WAIT    = 100;
  localparam int RDY_WAIT     = 8;
  localparam int DATA_CYCLES  = 500;
  localparam int DRAIN_WAIT   = 200;
  localparam int TOTAL_CYCLES = RESET_CYCLES +
                                SEGMENTS * (LINK_WAIT + RDY_WAIT + DATA_CYCLES + DRAIN_WAIT + 4);
  localparam int WATCHDOG_NS  = 4 * TOTAL_CYCLES * 8;

  logic        CLK_IN;
  logic        RESET_IN;
  word_t       tx_data_i;
  charisk_t    tx_charisk_i;
  logic        tx_vld_i;
  logic        tx_rdy_o;
  word_t       txdata_o;
  charisk_t    txcharisk_o;
  word_t       rxdata_i;
  charisk_t    rxcharisk_i;
  logic        loss_of_sync_i;
  word_t       rx_data_o;
  charisk_t    rx_charisk_o;
  logic        rx_vld_o;
  logic        link_up_o;

  // Testbench state
  word_t       word_q[$];
  logic        traffic_en;
  logic        sync_req;
  logic        accepted_q;
  logic        rdy_prev;
  rot_t        rotation;
  word_t       last_txdata;
  charisk_t    last_txk;
  logic [63:0] pair_d;
  logic [7:0]  pair_k;
  int          cc_age;
  logic        cc_seen;
  int          delivered;
  int unsigned seed_val;

  hss_link_top u_hss_link_top
  (
    .CLK_IN         (CLK_IN),
    .RESET_IN       (RESET_IN),
    .tx_data_i      (tx_data_i),
    .tx_charisk_i   (tx_charisk_i),
    .tx_vld_i       (tx_vld_i),
    .tx_rdy_o       (tx_rdy_o),
    .txdata_o       (txdata_o),
    .txcharisk_o    (txcharisk_o),
    .rxdata_i       (rxdata_i),
    .rxcharisk_i    (rxcharisk_i),
    .loss_of_sync_i (loss_of_sync_i),
    .rx_data_o      (rx_data_o),
    .rx_charisk_o   (rx_charisk_o),
    .rx_vld_o       (rx_vld_o),
    .link_up_o      (link_up_o)
  );

  // 8 ns clock
  always #4 CLK_IN = ~CLK_IN;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string what, input word_t got_d, input charisk_t got_k,
                            input word_t exp_d, input charisk_t exp_k);
    if (got_d !== exp_d || got_k !== exp_k)
      fail_run($sformatf("MISMATCH at %0t: %s data %h flags %b, expected %h flags %b",
                         $time, what, got_d, got_k, exp_d, exp_k));
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp)
      fail_run($sformatf("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp));
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp)
      fail_run($sformatf("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp));
  endtask

  // Waits for a status output with a bound in cycles
  task automatic wait_link_up(input int limit);
    int n;
    n = 0;
    while (!link_up_o)
    begin
      if (n >= limit)
        fail_run($sformatf("link_up_o did not rise within %0d cycles", limit));
      @(negedge CLK_IN);
      n++;
    end
  endtask

  task automatic wait_tx_ready(input int limit);
    int n;
    n = 0;
    while (!tx_rdy_o)
    begin
      if (n >= limit)
        fail_run("tx_rdy_o did not follow link_up_o");
      @(negedge CLK_IN);
      n++;
    end
  endtask

  // Queue must stay empty long enough to cover a held word and the pipeline
  task automatic drain_queue(input int limit);
    int quiet;
    int n;
    quiet = 0;
    n     = 0;
    while (quiet < 12)
    begin
      @(negedge CLK_IN);
      n++;
      if (word_q.size() == 0)
        quiet++;
      else
        quiet = 0;
      if (n > limit)
        fail_run("accepted words were not delivered on the receive side");
    end
  endtask

  // Upstream source, loss of sync and loopback, all on the falling edge
  always @(negedge CLK_IN)
  begin
    // Word is held until it transfers
    if (!(tx_vld_i && !accepted_q))
    begin
      tx_vld_i  = traffic_en && (($urandom % 4) != 0);
      tx_data_i = $urandom;
    end
    // New rotation goes with the pulse
    if (sync_req)
    begin
      loss_of_sync_i = 1'b1;
      rotation       = rotation + rot_t'(1 + ($urandom % 3));
      sync_req       = 1'b0;
    end
    else
      loss_of_sync_i = 1'b0;
    // Byte stream shifted by the rotation across word boundaries
    pair_d      = {last_txdata, txdata_o} >> (8 * rotation);
    pair_k      = {last_txk, txcharisk_o} >> rotation;
    rxdata_i    = pair_d[31:0];
    rxcharisk_i = pair_k[3:0];
    last_txdata = txdata_o;
    last_txk    = txcharisk_o;
  end

  // Monitor sees the values held up to each rising edge
  always @(posedge CLK_IN)
  begin
    if (!RESET_IN)
    begin
      // Receive side against the reference queue
      if (rx_vld_o)
      begin
        if (word_q.size() == 0)
          fail_run("rx_vld_o went high while no accepted word was outstanding");
        else
        begin
          check_word("received word", rx_data_o, rx_charisk_o, word_q[0], 4'b0000);
          void'(word_q.pop_front());
          delivered++;
        end
      end
      // Clock correction slot spacing
      cc_age++;
      if (cc_seen && cc_age == CC_INTERVAL + 1)
      begin
        // Slot is due whatever the flags show
        check_word("clock correction word", txdata_o, txcharisk_o, {4{KCH_CLKC}}, 4'b1111);
        check_flag("tx_rdy_o before clock correction", rdy_prev, 1'b0);
        cc_age = 0;
      end
      else if (txcharisk_o == 4'b1111)
      begin
        // First slot after reset sets the spacing reference
        if (cc_seen)
          check_count("clock correction spacing", cc_age, CC_INTERVAL + 1);
        check_word("clock correction word", txdata_o, txcharisk_o, {4{KCH_CLKC}}, 4'b1111);
        check_flag("tx_rdy_o before clock correction", rdy_prev, 1'b0);
        cc_age  = 0;
        cc_seen = 1'b1;
      end
      // Model queue, flushed on loss of sync
      accepted_q = tx_rdy_o && tx_vld_i;
      if (loss_of_sync_i)
        word_q.delete();
      else if (accepted_q)
        word_q.push_back(tx_data_i);
      rdy_prev = tx_rdy_o;
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    fail_run("watchdog expired before the tests finished");
  end

  initial
  begin
    CLK_IN         = 1'b0;
    RESET_IN       = 1'b1;
    tx_data_i      = '0;
    tx_charisk_i   = '0;
    tx_vld_i       = 1'b0;
    rxdata_i       = '0;
    rxcharisk_i    = '0;
    loss_of_sync_i = 1'b0;
    traffic_en     = 1'b0;
    sync_req       = 1'b0;
    accepted_q     = 1'b0;
    rdy_prev       = 1'b0;
    last_txdata    = '0;
    last_txk       = '0;
    cc_age         = 0;
    cc_seen        = 1'b0;
    delivered      = 0;
    seed_val       = 32'h675e;
    rotation       = rot_t'($urandom(seed_val) % 4);
    repeat (RESET_CYCLES) @(negedge CLK_IN);
    check_word("transmit word in reset", txdata_o, txcharisk_o, '0, '0);
    RESET_IN = 1'b0;
    @(negedge CLK_IN);
    check_flag("tx_rdy_o after reset", tx_rdy_o, 1'b0);
    check_flag("rx_vld_o after reset", rx_vld_o, 1'b0);
    check_flag("link_up_o after reset", link_up_o, 1'b0);
    for (int seg = 0; seg < SEGMENTS; seg++)
    begin
      if (seg > 0)
      begin
        // Pulse is driven on the next falling edge
        @(posedge CLK_IN);
        sync_req = 1'b1;
        @(negedge CLK_IN);
        @(negedge CLK_IN);
        check_flag("link_up_o after loss of sync", link_up_o, 1'b0);
      end
      wait_link_up(LINK_WAIT);
      wait_tx_ready(RDY_WAIT);
      @(posedge CLK_IN);
      traffic_en = 1'b1;
      repeat (DATA_CYCLES) @(posedge CLK_IN);
      traffic_en = 1'b0;
      drain_queue(DRAIN_WAIT);
    end
    if (word_q.size() != 0 || delivered < SEGMENTS * DATA_CYCLES / 2)
      fail_run($sformatf("too few words delivered, %0d received", delivered));
    else
    begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

/* files.f */
logic/hss_link_pkg.sv
logic/hss_word_if.sv
logic/hss_tx_control.sv
logic/hss_rx_control.sv
logic/hss_handshake_fsm.sv
logic/hss_link_top.sv
bench/hss_link_tb.sv

/* logic/hss_handshake_fsm.sv */
// ----------------------------------------------------------
// Handshake state machine of the link
// Inputs are expected already version checked
// ----------------------------------------------------------
`timescale 1ns/10ps

module hss_handshake_fsm
(
  input  logic CLK_IN,
  input  logic RESET_IN,
  input  logic hs_seen_i,
  input  logic hs_phase_i,
  input  logic data_seen_i,
  input  logic loss_of_sync_i,
  output logic hs_phase_o,
  output logic hs_complete_o
);
  import hss_link_pkg::*;

  hs_state_t state_q;
  hs_state_t state_d;

  // Next state
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      HS_PHASE0:
        // Remote is alive and compatible
        if (hs_seen_i)
          state_d = HS_PHASE1;
      HS_PHASE1:
        // Remote has seen us too
        if ((hs_seen_i && hs_phase_i) || data_seen_i)
          state_d = HS_COMPLETE;
      HS_COMPLETE:
        state_d = HS_COMPLETE;
      default:
        state_d = HS_PHASE0;
    endcase
    // Restart from scratch whenever sync is lost
    if (loss_of_sync_i)
      state_d = HS_PHASE0;
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN)
  begin
    if (RESET_IN)
      state_q <= HS_PHASE0;
    else
      state_q <= state_d;
  end

  // Phase bit stays set once past phase 0
  assign hs_phase_o    = (state_q != HS_PHASE0);
  assign hs_complete_o = (state_q == HS_COMPLETE);

endmodule

/* logic/hss_link_pkg.sv */
// ----------------------------------------------------------
// Shared types and constants of the serial link control layer
// K codes follow 8b/10b control characters
// CC_INTERVAL may change since the counter width derives from it
// ----------------------------------------------------------
package hss_link_pkg;

  // One link word and its per-lane K flags
  typedef logic [31:0] word_t;
  typedef logic [3:0]  charisk_t;
  typedef logic [7:0]  byte_t;

  // Byte rotation of the receive alignment, 0 to 3 bytes
  typedef logic [1:0] rot_t;

  // Control characters
  localparam byte_t KCH_COMMA     = 8'hBC;
  localparam byte_t KCH_HANDSHAKE = 8'hFB;
  localparam byte_t KCH_CLKC      = 8'h1C;
  localparam byte_t KCH_IDLE      = 8'h3C;

  // Protocol version carried in byte 0 of every handshake
  localparam byte_t LINK_VERSION = 8'h01;

  // Cycles between clock correction sequences
  localparam int CC_INTERVAL = 64;
  localparam int CC_CNT_W    = $clog2(CC_INTERVAL + 1);
  typedef logic [CC_CNT_W-1:0] cc_cnt_t;

  // K flag patterns of the word kinds
  localparam charisk_t CHARISK_DATA = 4'b0000;
  localparam charisk_t CHARISK_CTRL = 4'b1100;
  localparam charisk_t CHARISK_CLKC = 4'b1111;

  // Fixed special words
  localparam word_t CC_WORD   = {4{KCH_CLKC}};
  localparam word_t IDLE_WORD = {KCH_COMMA, KCH_IDLE, 16'h0000};

  // Handshake progress
  typedef enum logic [1:0]
  {
    HS_PHASE0,
    HS_PHASE1,
    HS_COMPLETE
  } hs_state_t;

endpackage

/* logic/hss_link_top.sv */
// ----------------------------------------------------------
// Link control layer top with transmit, receive and handshake
// Receive path has no back pressure
// Data in flight may be lost on loss of sync
// ----------------------------------------------------------
`timescale 1ns/10ps

module hss_link_top
(
  input  logic                   CLK_IN,
  input  logic                   RESET_IN,
  // Upstream transmit words
  input  hss_link_pkg::word_t    tx_data_i,
  input  hss_link_pkg::charisk_t tx_charisk_i,
  input  logic                   tx_vld_i,
  output logic                   tx_rdy_o,
  // Transceiver transmit side
  output hss_link_pkg::word_t    txdata_o,
  output hss_link_pkg::charisk_t txcharisk_o,
  // Transceiver receive side
  input  hss_link_pkg::word_t    rxdata_i,
  input  hss_link_pkg::charisk_t rxcharisk_i,
  input  logic                   loss_of_sync_i,
  // Downstream receive words
  output hss_link_pkg::word_t    rx_data_o,
  output hss_link_pkg::charisk_t rx_charisk_o,
  output logic                   rx_vld_o,
  output logic                   link_up_o
);

  logic hs_phase;
  logic hs_complete;

  hss_word_if u_rx_word ();

  hss_tx_control u_tx_control
  (
    .CLK_IN        (CLK_IN),
    .RESET_IN      (RESET_IN),
    .hs_complete_i (hs_complete),
    .hs_phase_i    (hs_phase),
    .tx_data_i     (tx_data_i),
    .tx_charisk_i  (tx_charisk_i),
    .tx_vld_i      (tx_vld_i),
    .tx_rdy_o      (tx_rdy_o),
    .txdata_o      (txdata_o),
    .txcharisk_o   (txcharisk_o)
  );

  hss_rx_control u_rx_control
  (
    .CLK_IN         (CLK_IN),
    .RESET_IN       (RESET_IN),
    .rxdata_i       (rxdata_i),
    .rxcharisk_i    (rxcharisk_i),
    .loss_of_sync_i (loss_of_sync_i),
    .rx             (u_rx_word.src)
  );

  // Remote handshakes and data words drive the handshake
  hss_handshake_fsm u_handshake_fsm
  (
    .CLK_IN         (CLK_IN),
    .RESET_IN       (RESET_IN),
    .hs_seen_i      (u_rx_word.hs_seen),
    .hs_phase_i     (u_rx_word.hs_phase),
    .data_seen_i    (u_rx_word.vld),
    .loss_of_sync_i (loss_of_sync_i),
    .hs_phase_o     (hs_phase),
    .hs_complete_o  (hs_complete)
  );

  // Data half of the word path goes downstream
  assign rx_data_o    = u_rx_word.data;
  assign rx_charisk_o = u_rx_word.charisk;
  assign rx_vld_o     = u_rx_word.vld;
  assign link_up_o    = hs_complete;

endmodule

/* logic/hss_rx_control.sv */
// ----------------------------------------------------------
// Receive alignment and word filtering
// Lock is taken from the first comma seen in any lane
// Loss of sync drops the lock and the word of that cycle
// ----------------------------------------------------------
`timescale 1ns/10ps

module hss_rx_control
(
  input  logic                   CLK_IN,
  input  logic                   RESET_IN,
  input  hss_link_pkg::word_t    rxdata_i,
  input  hss_link_pkg::charisk_t rxcharisk_i,
  input  logic                   loss_of_sync_i,
  hss_word_if.src                rx
);
  import hss_link_pkg::*;

  word_t       prev_data_q;
  charisk_t    prev_k_q;
  logic        locked_q;
  rot_t        rot_q;
  logic        comma_found;
  rot_t        comma_rot;
  logic [63:0] pair_data;
  logic [7:0]  pair_k;
  word_t       al_data;
  charisk_t    al_k;
  logic        vld_d;
  logic        hs_seen_d;
  word_t       data_q;
  charisk_t    k_q;
  logic        phase_q;
  logic        vld_q;
  logic        hs_seen_q;

  // Previous raw word completes a word split over two cycles
  always_ff @(posedge CLK_IN)
  begin
    prev_data_q <= rxdata_i;
    prev_k_q    <= rxcharisk_i;
  end

  // Comma search over all lanes
  // Highest lane wins since it is checked last
  always_comb
  begin
    comma_found = 1'b0;
    comma_rot   = '0;
    for (int i = 0; i < 4; i++)
    begin
      if (rxcharisk_i[i] && (rxdata_i[8*i +: 8] == KCH_COMMA))
      begin
        comma_found = 1'b1;
        comma_rot   = rot_t'(3 - i);
      end
    end
  end

  // Alignment lock
  always_ff @(posedge CLK_IN or posedge RESET_IN)
  begin
    if (RESET_IN)
    begin
      locked_q <= 1'b0;
      rot_q    <= '0;
    end
    else if (loss_of_sync_i)
      locked_q <= 1'b0;
    else if (!locked_q && comma_found)
    begin
      locked_q <= 1'b1;
      rot_q    <= comma_rot;
    end
  end

  // Aligned word starts rot_q bytes below the top of the older word
  assign pair_data = {prev_data_q, rxdata_i};
  assign pair_k    = {prev_k_q, rxcharisk_i};
  assign al_data   = pair_data[63 - 8 * int'(rot_q) -: 32];
  assign al_k      = pair_k[7 - int'(rot_q) -: 4];

  // Word classification
  always_comb
  begin
    vld_d     = 1'b0;
    hs_seen_d = 1'b0;
    if (locked_q && !loss_of_sync_i)
    begin
      case (al_k)
        CHARISK_DATA:
          vld_d = 1'b1;
        CHARISK_CTRL:
          // Idle shares these flags and is dropped here
          hs_seen_d = (al_data[31:24] == KCH_COMMA) &&
                      (al_data[23:16] == KCH_HANDSHAKE) &&
                      (al_data[7:0] == LINK_VERSION);
        default:
          // Clock correction and unknown K words
          vld_d = 1'b0;
      endcase
    end
  end

  // Output stage strobes
  always_ff @(posedge CLK_IN or posedge RESET_IN)
  begin
    if (RESET_IN)
    begin
      vld_q     <= 1'b0;
      hs_seen_q <= 1'b0;
    end
    else
    begin
      vld_q     <= vld_d;
      hs_seen_q <= hs_seen_d;
    end
  end

  // Output stage payload
  always_ff @(posedge CLK_IN)
  begin
    data_q  <= al_data;
    k_q     <= al_k;
    phase_q <= al_data[8];
  end

  assign rx.data     = data_q;
  assign rx.charisk  = k_q;
  assign rx.vld      = vld_q;
  assign rx.hs_seen  = hs_seen_q;
  assign rx.hs_phase = phase_q;

endmodule

/* logic/hss_tx_control.sv */
// ----------------------------------------------------------
// Transmit word selection for the serial link
// Upstream words need zero K flags and must stay stable until accepted
// Accepted words leave two cycles after tx_rdy_o and tx_vld_i
// ----------------------------------------------------------
`timescale 1ns/10ps

module hss_tx_control
(
  input  logic                   CLK_IN,
  input  logic                   RESET_IN,
  input  logic                   hs_complete_i,
  input  logic                   hs_phase_i,
  input  hss_link_pkg::word_t    tx_data_i,
  input  hss_link_pkg::charisk_t tx_charisk_i,
  input  logic                   tx_vld_i,
  output logic                   tx_rdy_o,
  output hss_link_pkg::word_t    txdata_o,
  output hss_link_pkg::charisk_t txcharisk_o
);
  import hss_link_pkg::*;

  cc_cnt_t  cc_cnt_q;
  logic     cc_gap;
  logic     send_cc_q;
  logic     send_hs_q;
  logic     tx_accept;
  logic     acc_q;
  word_t    hold_data_q;
  charisk_t hold_k_q;

  // Interval counter wraps after CC_INTERVAL
  always_ff @(posedge CLK_IN or posedge RESET_IN)
  begin
    if (RESET_IN)
      cc_cnt_q <= '0;
    else if (cc_cnt_q == cc_cnt_t'(CC_INTERVAL))
      cc_cnt_q <= '0;
    else
      cc_cnt_q <= cc_cnt_q + 1'b1;
  end

  // Ready is withheld around the correction slot
  assign cc_gap    = (cc_cnt_q == cc_cnt_t'(CC_INTERVAL)) || (cc_cnt_q == '0);
  assign tx_accept = tx_rdy_o && tx_vld_i;

  // Slot decisions registered one cycle ahead of the output stage
  always_ff @(posedge CLK_IN or posedge RESET_IN)
  begin
    if (RESET_IN)
    begin
      send_cc_q <= 1'b0;
      send_hs_q <= 1'b1;
      acc_q     <= 1'b0;
      tx_rdy_o  <= 1'b0;
    end
    else
    begin
      send_cc_q <= (cc_cnt_q == '0);
      send_hs_q <= !hs_complete_i;
      acc_q     <= tx_accept;
      tx_rdy_o  <= hs_complete_i && !cc_gap;
    end
  end

  // Holding stage for an accepted upstream word
  always_ff @(posedge CLK_IN)
  begin
    if (tx_accept)
    begin
      hold_data_q <= tx_data_i;
      hold_k_q    <= tx_charisk_i;
    end
  end

  // Output word by priority
  always_ff @(posedge CLK_IN or posedge RESET_IN)
  begin
    if (RESET_IN)
    begin
      txdata_o    <= '0;
      txcharisk_o <= '0;
    end
    else if (send_cc_q)
    begin
      txdata_o    <= CC_WORD;
      txcharisk_o <= CHARISK_CLKC;
    end
    else if (send_hs_q)
    begin
      // Phase in bit 0 of byte 1, version in byte 0
      txdata_o    <= {KCH_COMMA, KCH_HANDSHAKE, 7'b0000000, hs_phase_i, LINK_VERSION};
      txcharisk_o <= CHARISK_CTRL;
    end
    else if (acc_q)
    begin
      txdata_o    <= hold_data_q;
      txcharisk_o <= hold_k_q;
    end
    else
    begin
      // Nothing accepted so fill with idle
      txdata_o    <= IDLE_WORD;
      txcharisk_o <= CHARISK_CTRL;
    end
  end

endmodule

/* logic/hss_word_if.sv */
// ----------------------------------------------------------
// Received word path after alignment and filtering
// hs_seen is set only for handshakes with a matching version
// ----------------------------------------------------------
`timescale 1ns/10ps

interface hss_word_if;
  import hss_link_pkg::*;

  // Aligned word and its flags
  word_t    data;
  charisk_t charisk;
  // Data word strobe
  logic     vld;
  // Decoded remote handshake and its phase bit
  logic     hs_seen;
  logic     hs_phase;

  // Receive control drives the path
  modport src (output data, output charisk, output vld, output hs_seen, output hs_phase);

  // Link top reads it
  modport snk (input data, input charisk, input vld, input hs_seen, input hs_phase);

endinterface
